//--- sim.f
rtl/mipsIsaPkg.sv
rtl/cpuCfgPkg.sv
rtl/decodeBus.sv
rtl/instrDecoder.sv
rtl/executeUnit.sv
rtl/nextPcUnit.sv
rtl/registerFile.sv
rtl/mipsCpuHarvard.sv
tests/cpuChecker.sv
tests/tbMipsCpu.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert
TOP = tbMipsCpu
FILELIST = sim.f
BUILD_DIR = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(BUILD_DIR)

//--- tests/tbMipsCpu.sv
`timescale 1ns/1ns

module tbMipsCpu;
  import mipsIsaPkg::*;
  import cpuCfgPkg::*;

  localparam int clkPeriod = 40;
  localparam int imemDepth = 16;
  localparam int testSlot = 4;
  localparam int cycleBudget = 24;
  localparam logic [15:0] markerTaken = 16'hA5A5;
  localparam logic [15:0] markerFall = 16'h5A5A;
  localparam logic [4:0] regT0 = 5'd8;
  localparam logic [4:0] regT1 = 5'd9;
  localparam logic [4:0] regV0 = 5'(v0Reg);
  localparam logic [4:0] regRa = 5'(linkReg);

  logic clk;
  logic reset;
  logic clkEnable;
  logic active;
  logic [31:0] registerV0;
  logic [31:0] instrAddress;
  logic [31:0] instrReadData;
  logic [31:0] dataAddress;
  logic dataWrite;
  logic dataRead;
  logic [31:0] dataWriteData;
  logic [31:0] dataReadData;

  logic [31:0] imem [imemDepth];
  logic [31:0] dmem [64];
  logic [31:0] imemIndex;
  logic [31:0] lfsr = 32'd45746;

  // Stimulus table with one element per test in each queue
  string names[$];
  logic [11:0] ops[$];
  logic [31:0] opA[$];
  logic [31:0] opB[$];
  bit randOps[$];
  bit immForm[$];
  bit stallRun[$];

  mipsCpuHarvard mipsCpuHarvard_i (
    .clk(clk), .reset(reset), .clkEnable(clkEnable), .active(active),
    .registerV0(registerV0), .instrAddress(instrAddress), .instrReadData(instrReadData),
    .dataAddress(dataAddress), .dataWrite(dataWrite), .dataRead(dataRead),
    .dataWriteData(dataWriteData), .dataReadData(dataReadData)
  );

  cpuChecker #(.testSlot(testSlot), .markerTaken(markerTaken), .markerFall(markerFall))
    checker_i (
    .clk(clk), .reset(reset), .active(active), .registerV0(registerV0),
    .instrAddress(instrAddress), .dataWrite(dataWrite), .dataRead(dataRead),
    .dataAddress(dataAddress), .dataWriteData(dataWriteData)
  );

  // Instruction memory sits at the reset vector and reads combinationally
  assign imemIndex = (instrAddress - resetVector) >> 2;
  assign instrReadData = (imemIndex < imemDepth) ? imem[imemIndex[3:0]] : '0;
  assign dataReadData = dmem[dataAddress[7:2]];

  always @(posedge clk)
  begin
    if (dataWrite)
      dmem[dataAddress[7:2]] <= dataWriteData;
  end

  initial
  begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  function automatic logic [31:0] galoisStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic drawWord(output logic [31:0] w);
    for (int i = 0; i < 32; i++)
    begin
      w = {w[30:0], lfsr[0]};
      lfsr = galoisStep(lfsr);
    end
  endtask

  function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
    input logic [4:0] rd, input logic [4:0] sa, input logic [5:0] fn);
    return {opSpecial, rs, rt, rd, sa, fn};
  endfunction

  function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
    input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic addEntry(input string name, input logic [11:0] op, input logic [31:0] a,
    input logic [31:0] b, input bit rnd, input bit imm, input bit stall);
    names.push_back(name);
    ops.push_back(op);
    opA.push_back(a);
    opB.push_back(b);
    randOps.push_back(rnd);
    immForm.push_back(imm);
    stallRun.push_back(stall);
  endtask

  task automatic buildProgram(input logic [11:0] op, input logic [31:0] a,
    input logic [31:0] b, input bit imm);
    logic [5:0] opc;
    logic [15:0] offset;
    logic [31:0] jalTarget;
    opc = op[11:6];
    offset = {8'h00, a[5:0], 2'b00};
    jalTarget = resetVector + 32'(4 * (testSlot + 2));
    // Whatever follows the test code is jr $zero, which halts
    for (int i = 0; i < imemDepth; i++)
      imem[i] = rType(5'd0, 5'd0, 5'd0, 5'd0, fnJr);
    imem[0] = iType(opLui, 5'd0, regT0, a[31:16]);
    imem[1] = iType(opOri, regT0, regT0, a[15:0]);
    imem[2] = iType(opLui, 5'd0, regT1, b[31:16]);
    imem[3] = iType(opOri, regT1, regT1, b[15:0]);
    if (opc == opSpecial && imm)
      imem[testSlot] = rType(5'd0, regT0, regV0, b[4:0], op[5:0]);
    else if (opc == opSpecial)
      imem[testSlot] = rType(regT0, regT1, regV0, 5'd0, op[5:0]);
    else if (opc == opSw)
    begin
      imem[testSlot] = iType(opSw, 5'd0, regT1, offset);
      imem[testSlot + 1] = iType(opLw, 5'd0, regV0, offset);
    end
    else if (opc == opBeq || opc == opBne)
    begin
      imem[testSlot] = iType(opOri, 5'd0, regV0, markerTaken);
      // One word offset skips the fall-through marker
      imem[testSlot + 1] = iType(opc, regT0, regT1, 16'd1);
      imem[testSlot + 2] = iType(opOri, 5'd0, regV0, markerFall);
    end
    else if (opc == opJal)
    begin
      imem[testSlot] = {opJal, jalTarget[27:2]};
      imem[testSlot + 1] = iType(opOri, 5'd0, regV0, markerFall);
      imem[testSlot + 2] = rType(regV0, regRa, regV0, 5'd0, fnAddu);
    end
    else
      imem[testSlot] = iType(opc, regT0, regV0, b[15:0]);
  endtask

  task automatic runTest(input int t);
    logic [31:0] a;
    logic [31:0] b;
    int cycles;
    int lowRun;
    a = opA[t];
    b = opB[t];
    if (randOps[t])
    begin
      drawWord(a);
      drawWord(b);
    end
    buildProgram(ops[t], a, b, immForm[t]);
    @(negedge clk);
    reset = 1'b1;
    clkEnable = 1'b1;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    cycles = 0;
    lowRun = 0;
    while (active && cycles < cycleBudget)
    begin
      @(negedge clk);
      cycles++;
      // Random stalls of at most two low cycles in a row
      if (stallRun[t] && lowRun >= 2)
        clkEnable = 1'b1;
      else if (stallRun[t])
      begin
        clkEnable = lfsr[0];
        lfsr = galoisStep(lfsr);
      end
      lowRun = clkEnable ? 0 : lowRun + 1;
    end
    clkEnable = 1'b1;
    if (active)
      checker_i.reportHang(names[t], cycleBudget);
    else
      checker_i.checkTest(names[t], ops[t], a, b);
  endtask

  initial
  begin
    reset = 1'b1;
    clkEnable = 1'b1;
    for (int i = 0; i < 64; i++)
      dmem[i] <= {16'hDA7A, 16'(i)};
    // name, selector, a, b, random, immediate form, stall
    addEntry("addu", {opSpecial, fnAddu}, 0, 0, 1, 0, 0);
    addEntry("subu", {opSpecial, fnSubu}, 0, 0, 1, 0, 0);
    addEntry("and", {opSpecial, fnAnd}, 0, 0, 1, 0, 0);
    addEntry("or", {opSpecial, fnOr}, 0, 0, 1, 0, 0);
    addEntry("xor", {opSpecial, fnXor}, 0, 0, 1, 0, 0);
    addEntry("nor", {opSpecial, fnNor}, 0, 0, 1, 0, 0);
    addEntry("slt", {opSpecial, fnSlt}, 0, 0, 1, 0, 0);
    addEntry("sltu", {opSpecial, fnSltu}, 0, 0, 1, 0, 0);
    addEntry("addiu", {opAddiu, 6'd0}, 0, 0, 1, 1, 0);
    addEntry("addiu negative", {opAddiu, 6'd0}, 32'd5, 32'h0000FFFF, 0, 1, 0);
    addEntry("andi zero ext", {opAndi, 6'd0}, 32'hFFFFFFFF, 32'h00008001, 0, 1, 0);
    addEntry("ori", {opOri, 6'd0}, 0, 0, 1, 1, 0);
    addEntry("xori", {opXori, 6'd0}, 0, 0, 1, 1, 0);
    addEntry("slti signed", {opSlti, 6'd0}, 32'd5, 32'h0000FFFE, 0, 1, 0);
    addEntry("sltiu sign ext", {opSltiu, 6'd0}, 32'h00010000, 32'h0000FFFF, 0, 1, 0);
    addEntry("lui", {opLui, 6'd0}, 0, 0, 1, 1, 0);
    addEntry("sll", {opSpecial, fnSll}, 0, 0, 1, 1, 0);
    addEntry("srl", {opSpecial, fnSrl}, 0, 0, 1, 1, 0);
    addEntry("sra negative", {opSpecial, fnSra}, 32'h80000000, 32'd4, 0, 1, 0);
    addEntry("sw lw", {opSw, 6'd0}, 0, 0, 1, 1, 0);
    addEntry("beq taken", {opBeq, 6'd0}, 32'h12345678, 32'h12345678, 0, 0, 0);
    addEntry("beq not taken", {opBeq, 6'd0}, 0, 0, 1, 0, 0);
    addEntry("bne taken", {opBne, 6'd0}, 0, 0, 1, 0, 0);
    addEntry("bne not taken", {opBne, 6'd0}, 32'hCAFEF00D, 32'hCAFEF00D, 0, 0, 0);
    addEntry("jal", {opJal, 6'd0}, 0, 0, 0, 0, 0);
    addEntry("addu stalled", {opSpecial, fnAddu}, 0, 0, 1, 0, 1);
    for (int t = 0; t < names.size(); t++)
      runTest(t);
    checker_i.printSummary();
    if (checker_i.failCount == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  // Watchdog sized at 40 cycles per table entry
  initial
  begin
    #1;
    repeat (names.size() * 40) @(posedge clk);
    $display("Watchdog expired before all %0d tests finished", names.size());
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- tests/cpuChecker.sv
`timescale 1ns/1ns

module cpuChecker #(
  parameter int testSlot = 4,
  parameter logic [15:0] markerTaken = 16'hA5A5,
  parameter logic [15:0] markerFall = 16'h5A5A
) (
  input logic clk,
  input logic reset,
  input logic active,
  input logic [cpuCfgPkg::wordWidth-1:0] registerV0,
  input logic [cpuCfgPkg::wordWidth-1:0] instrAddress,
  input logic dataWrite,
  input logic dataRead,
  input logic [cpuCfgPkg::wordWidth-1:0] dataAddress,
  input logic [cpuCfgPkg::wordWidth-1:0] dataWriteData
);
  import mipsIsaPkg::*;
  import cpuCfgPkg::*;

  int passCount = 0;
  int failCount = 0;
  logic sawStore;
  logic sawLoad;
  logic [31:0] storeAddress;
  logic [31:0] storeData;
  logic [31:0] loadAddress;

  // Data port traffic as the data memory sees it
  always @(posedge clk)
  begin
    if (reset)
    begin
      sawStore <= 1'b0;
      sawLoad <= 1'b0;
    end
    else
    begin
      if (dataWrite)
      begin
        sawStore <= 1'b1;
        storeAddress <= dataAddress;
        storeData <= dataWriteData;
      end
      if (dataRead)
      begin
        sawLoad <= 1'b1;
        loadAddress <= dataAddress;
      end
    end
  end

  // Reference result of each test program by MIPS-I rules
  function automatic logic [31:0] expectedV0(input logic [11:0] op, input logic [31:0] a,
    input logic [31:0] b);
    logic [31:0] signImm;
    signImm = {{16{b[15]}}, b[15:0]};
    case (op)
      {opSpecial, fnAddu}: return a + b;
      {opSpecial, fnSubu}: return a - b;
      {opSpecial, fnAnd}: return a & b;
      {opSpecial, fnOr}: return a | b;
      {opSpecial, fnXor}: return a ^ b;
      {opSpecial, fnNor}: return ~(a | b);
      {opSpecial, fnSlt}: return {31'd0, $signed(a) < $signed(b)};
      {opSpecial, fnSltu}: return {31'd0, a < b};
      {opSpecial, fnSll}: return a << b[4:0];
      {opSpecial, fnSrl}: return a >> b[4:0];
      {opSpecial, fnSra}: return $signed(a) >>> b[4:0];
      {opAddiu, 6'd0}: return a + signImm;
      {opSlti, 6'd0}: return {31'd0, $signed(a) < $signed(signImm)};
      {opSltiu, 6'd0}: return {31'd0, a < signImm};
      {opAndi, 6'd0}: return a & {16'd0, b[15:0]};
      {opOri, 6'd0}: return a | {16'd0, b[15:0]};
      {opXori, 6'd0}: return a ^ {16'd0, b[15:0]};
      {opLui, 6'd0}: return {b[15:0], 16'd0};
      {opSw, 6'd0}: return b;
      {opBeq, 6'd0}: return {16'd0, (a == b) ? markerTaken : markerFall};
      {opBne, 6'd0}: return {16'd0, (a != b) ? markerTaken : markerFall};
      // Link is the address after the jal
      {opJal, 6'd0}: return resetVector + 32'(4 * (testSlot + 1));
      default: return '0;
    endcase
  endfunction

  task automatic checkTest(input string name, input logic [11:0] op, input logic [31:0] a,
    input logic [31:0] b);
    logic [31:0] expected;
    logic [31:0] haltV0;
    logic [31:0] addrExpected;
    logic [63:0] storeExpected;
    bit ok;
    bit moved;
    expected = expectedV0(op, a, b);
    addrExpected = {24'd0, a[5:0], 2'b00};
    storeExpected = {addrExpected, b};
    ok = (registerV0 === expected);
    moved = 1'b0;
    if (!ok)
      $display("FAILED %s: expected %h, actual %h", name, expected, registerV0);
    if (op[11:6] != opSw && (sawStore || sawLoad))
    begin
      ok = 1'b0;
      $display("%s: unexpected traffic on the data port", name);
    end
    else if (op[11:6] == opSw && !(sawStore && sawLoad))
    begin
      ok = 1'b0;
      $display("%s: the store or the load never reached the data port", name);
    end
    else if (op[11:6] == opSw && {storeAddress, storeData} !== storeExpected)
    begin
      ok = 1'b0;
      $display("FAILED %s store: expected %h, actual %h", name, storeExpected,
        {storeAddress, storeData});
    end
    else if (op[11:6] == opSw && loadAddress !== addrExpected)
    begin
      ok = 1'b0;
      $display("FAILED %s load: expected %h, actual %h", name, addrExpected, loadAddress);
    end
    // Halted core must keep still at address zero
    haltV0 = registerV0;
    for (int i = 0; i < 10; i++)
    begin
      @(negedge clk);
      moved = moved | active | (registerV0 !== haltV0) | (instrAddress !== '0);
    end
    if (moved)
    begin
      ok = 1'b0;
      $display("%s: the core did not stay halted at address zero with v0 stable", name);
    end
    if (ok)
    begin
      passCount++;
      $display("ok %s: v0 = %h", name, registerV0);
    end
    else
      failCount++;
  endtask

  task automatic reportHang(input string name, input int budget);
    failCount++;
    $display("%s: active never fell within %0d cycles", name, budget);
  endtask

  task automatic printSummary();
    $display("Tests: %0d run, %0d passed, %0d failed", passCount + failCount, passCount,
      failCount);
  endtask

endmodule

//--- rtl/mipsCpuHarvard.sv
`timescale 1ns/1ns

module mipsCpuHarvard (
  input logic clk,
  input logic reset,
  input logic clkEnable,
  output logic active,
  output logic [cpuCfgPkg::wordWidth-1:0] registerV0,
  output logic [cpuCfgPkg::wordWidth-1:0] instrAddress,
  input logic [cpuCfgPkg::wordWidth-1:0] instrReadData,
  output logic [cpuCfgPkg::wordWidth-1:0] dataAddress,
  output logic dataWrite,
  output logic dataRead,
  output logic [cpuCfgPkg::wordWidth-1:0] dataWriteData,
  input logic [cpuCfgPkg::wordWidth-1:0] dataReadData
);
  import cpuCfgPkg::*;

  logic [wordWidth-1:0] rsValue;
  logic [wordWidth-1:0] rtValue;
  logic [wordWidth-1:0] aluResult;
  logic [wordWidth-1:0] pcPlus4;

  decodeBus bus (.clk(clk));

  instrDecoder decoder_i (.instr(instrReadData), .bus(bus));

  executeUnit exec_i (
    .bus(bus), .rsValue(rsValue), .rtValue(rtValue), .aluResult(aluResult),
    .dataAddress(dataAddress), .dataWriteData(dataWriteData)
  );

  nextPcUnit nextPc_i (
    .clk(clk), .reset(reset), .clkEnable(clkEnable), .bus(bus),
    .rsValue(rsValue), .rtValue(rtValue), .pcPlus4(pcPlus4),
    .instrAddress(instrAddress), .active(active)
  );

  registerFile regFile_i (
    .clk(clk), .reset(reset), .clkEnable(clkEnable), .active(active), .bus(bus),
    .aluResult(aluResult), .memData(dataReadData), .pcPlus4(pcPlus4),
    .rsValue(rsValue), .rtValue(rtValue), .registerV0(registerV0)
  );

  // No memory traffic once halted
  assign dataWrite = bus.memWrite && active;
  assign dataRead = bus.memRead && active;

endmodule

//--- rtl/registerFile.sv
`timescale 1ns/1ns

module registerFile (
  input logic clk,
  input logic reset,
  input logic clkEnable,
  input logic active,
  decodeBus.regs bus,
  input logic [cpuCfgPkg::wordWidth-1:0] aluResult,
  input logic [cpuCfgPkg::wordWidth-1:0] memData,
  input logic [cpuCfgPkg::wordWidth-1:0] pcPlus4,
  output logic [cpuCfgPkg::wordWidth-1:0] rsValue,
  output logic [cpuCfgPkg::wordWidth-1:0] rtValue,
  output logic [cpuCfgPkg::wordWidth-1:0] registerV0
);
  import mipsIsaPkg::*;
  import cpuCfgPkg::*;

  logic [wordWidth-1:0] regs [regCount];
  logic [wordWidth-1:0] writeData;
  logic writeEn;

  // Writeback picks the link address, load data or ALU result
  always_comb
  begin
    if (bus.link)
      writeData = pcPlus4;
    else if (bus.memToReg)
      writeData = memData;
    else
      writeData = aluResult;
  end

  assign writeEn = clkEnable && active && bus.regWrite &&
    (bus.destReg != {regAddrWidth{1'b0}});

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < regCount; i++)
        regs[i] <= '0;
    end
    else if (writeEn)
      regs[bus.destReg] <= writeData;
  end

  // $zero is cleared at reset and never written, so it reads back zero
  assign rsValue = regs[bus.rs];
  assign rtValue = regs[bus.rt];
  assign registerV0 = regs[v0Reg];

  assert property (@(posedge clk) !reset |=> regs[0] == '0);

endmodule

//--- rtl/nextPcUnit.sv
`timescale 1ns/1ns

module nextPcUnit (
  input logic clk,
  input logic reset,
  input logic clkEnable,
  decodeBus.pc bus,
  input logic [cpuCfgPkg::wordWidth-1:0] rsValue,
  input logic [cpuCfgPkg::wordWidth-1:0] rtValue,
  output logic [cpuCfgPkg::wordWidth-1:0] pcPlus4,
  output logic [cpuCfgPkg::wordWidth-1:0] instrAddress,
  output logic active
);
  import mipsIsaPkg::*;
  import cpuCfgPkg::*;

  logic [wordWidth-1:0] pcReg;
  logic [wordWidth-1:0] branchTarget;
  logic [wordWidth-1:0] jumpTarget;
  logic [wordWidth-1:0] nextPc;
  logic operandsEqual;
  logic branchTaken;

  assign instrAddress = pcReg;
  assign pcPlus4 = pcReg + wordWidth'(4);

  // Branch offset counts words relative to the following instruction
  assign branchTarget = pcPlus4 + {{(wordWidth-immWidth-2){bus.imm16[immWidth-1]}},
    bus.imm16, 2'b00};
  assign jumpTarget = {pcPlus4[wordWidth-1:targetWidth+2], bus.target26, 2'b00};

  assign operandsEqual = (rsValue == rtValue);
  assign branchTaken = (bus.branchEq && operandsEqual) || (bus.branchNe && !operandsEqual);

  always_comb
  begin
    if (bus.jumpReg)
      nextPc = rsValue;
    else if (bus.jump)
      nextPc = jumpTarget;
    else if (branchTaken)
      nextPc = branchTarget;
    else
      nextPc = pcPlus4;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pcReg <= resetVector;
      active <= 1'b1;
    end
    else if (clkEnable && active)
    begin
      pcReg <= nextPc;
      // Transfer to address zero halts the core
      if (nextPc == '0)
      begin
        active <= 1'b0;
      end
    end
  end

  // Fetches stay word aligned while running
  assert property (@(posedge clk) disable iff (reset) active |-> instrAddress[1:0] == 2'b00);

endmodule

//--- rtl/executeUnit.sv
`timescale 1ns/1ns

module executeUnit (
  decodeBus.exec bus,
  input logic [cpuCfgPkg::wordWidth-1:0] rsValue,
  input logic [cpuCfgPkg::wordWidth-1:0] rtValue,
  output logic [cpuCfgPkg::wordWidth-1:0] aluResult,
  output logic [cpuCfgPkg::wordWidth-1:0] dataAddress,
  output logic [cpuCfgPkg::wordWidth-1:0] dataWriteData
);
  import mipsIsaPkg::*;
  import cpuCfgPkg::*;

  logic [wordWidth-1:0] signImm;
  logic [wordWidth-1:0] zeroImm;
  logic [wordWidth-1:0] opB;

  assign signImm = {{(wordWidth-immWidth){bus.imm16[immWidth-1]}}, bus.imm16};
  assign zeroImm = {{(wordWidth-immWidth){1'b0}}, bus.imm16};

  // Logical immediates are zero extended, the rest sign extended
  assign opB = !bus.aluSrcImm ? rtValue : (bus.zeroExtImm ? zeroImm : signImm);

  always_comb
  begin
    case (bus.aluOp)
      aluAdd: aluResult = rsValue + opB;
      aluSub: aluResult = rsValue - opB;
      aluAnd: aluResult = rsValue & opB;
      aluOr: aluResult = rsValue | opB;
      aluXor: aluResult = rsValue ^ opB;
      aluNor: aluResult = ~(rsValue | opB);
      aluSlt: aluResult = {{(wordWidth-1){1'b0}}, $signed(rsValue) < $signed(opB)};
      aluSltu: aluResult = {{(wordWidth-1){1'b0}}, rsValue < opB};
      // Shift amounts come from the shamt field only
      aluSll: aluResult = opB << bus.shamt;
      aluSrl: aluResult = opB >> bus.shamt;
      aluSra: aluResult = $signed(opB) >>> bus.shamt;
      aluLui: aluResult = {bus.imm16, {(wordWidth-immWidth){1'b0}}};
      default: aluResult = '0;
    endcase
  end

  // Word address for lw and sw
  assign dataAddress = rsValue + signImm;
  assign dataWriteData = rtValue;

  // A single instruction never both loads and stores
  assert property (@(posedge bus.clk) !(bus.memRead && bus.memWrite));

endmodule

//--- rtl/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder (
  input logic [cpuCfgPkg::wordWidth-1:0] instr,
  decodeBus.decoder bus
);
  import mipsIsaPkg::*;
  import cpuCfgPkg::*;

  logic [opWidth-1:0] opcode;
  logic [opWidth-1:0] funct;

  assign opcode = instr[31:26];
  assign funct = instr[5:0];

  // Raw instruction fields
  assign bus.rs = instr[25:21];
  assign bus.rt = instr[20:16];
  assign bus.shamt = instr[10:6];
  assign bus.imm16 = instr[15:0];
  assign bus.target26 = instr[25:0];

  always_comb
  begin
    // Anything not matched below behaves as a no-op
    bus.destReg = instr[15:11];
    bus.aluOp = aluAdd;
    bus.aluSrcImm = 1'b0;
    bus.zeroExtImm = 1'b0;
    bus.regWrite = 1'b0;
    bus.memRead = 1'b0;
    bus.memWrite = 1'b0;
    bus.memToReg = 1'b0;
    bus.link = 1'b0;
    bus.branchEq = 1'b0;
    bus.branchNe = 1'b0;
    bus.jump = 1'b0;
    bus.jumpReg = 1'b0;
    case (opcode)
      opSpecial:
      begin
        bus.regWrite = 1'b1;
        case (funct)
          fnSll: bus.aluOp = aluSll;
          fnSrl: bus.aluOp = aluSrl;
          fnSra: bus.aluOp = aluSra;
          fnAddu: bus.aluOp = aluAdd;
          fnSubu: bus.aluOp = aluSub;
          fnAnd: bus.aluOp = aluAnd;
          fnOr: bus.aluOp = aluOr;
          fnXor: bus.aluOp = aluXor;
          fnNor: bus.aluOp = aluNor;
          fnSlt: bus.aluOp = aluSlt;
          fnSltu: bus.aluOp = aluSltu;
          fnJr:
          begin
            bus.regWrite = 1'b0;
            bus.jumpReg = 1'b1;
          end
          default: bus.regWrite = 1'b0;
        endcase
      end
      opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui, opLw:
      begin
        // I-type results land in rt
        bus.destReg = instr[20:16];
        bus.aluSrcImm = 1'b1;
        bus.regWrite = 1'b1;
        bus.zeroExtImm = (opcode == opAndi) || (opcode == opOri) || (opcode == opXori);
        case (opcode)
          opSlti: bus.aluOp = aluSlt;
          opSltiu: bus.aluOp = aluSltu;
          opAndi: bus.aluOp = aluAnd;
          opOri: bus.aluOp = aluOr;
          opXori: bus.aluOp = aluXor;
          opLui: bus.aluOp = aluLui;
          opLw:
          begin
            bus.memRead = 1'b1;
            bus.memToReg = 1'b1;
          end
          default: bus.aluOp = aluAdd;
        endcase
      end
      opSw: bus.memWrite = 1'b1;
      opBeq: bus.branchEq = 1'b1;
      opBne: bus.branchNe = 1'b1;
      opJ: bus.jump = 1'b1;
      opJal:
      begin
        bus.jump = 1'b1;
        bus.link = 1'b1;
        bus.regWrite = 1'b1;
        bus.destReg = regAddrWidth'(linkReg);
      end
      default: bus.regWrite = 1'b0;
    endcase
  end

endmodule

//--- rtl/decodeBus.sv
`timescale 1ns/1ns

interface decodeBus (input logic clk);
  import mipsIsaPkg::*;

  logic [regAddrWidth-1:0] rs;
  logic [regAddrWidth-1:0] rt;
  logic [regAddrWidth-1:0] destReg;
  logic [immWidth-1:0] imm16;
  logic [shamtWidth-1:0] shamt;
  logic [targetWidth-1:0] target26;
  aluOp_t aluOp;
  logic aluSrcImm;
  logic zeroExtImm;
  logic regWrite;
  logic memRead;
  logic memWrite;
  logic memToReg;
  logic link;
  logic branchEq;
  logic branchNe;
  logic jump;
  logic jumpReg;

  modport decoder (output rs, rt, destReg, imm16, shamt, target26, aluOp, aluSrcImm,
    zeroExtImm, regWrite, memRead, memWrite, memToReg, link, branchEq, branchNe,
    jump, jumpReg);
  modport exec (input clk, aluOp, aluSrcImm, zeroExtImm, imm16, shamt, memRead, memWrite);
  modport pc (input imm16, target26, branchEq, branchNe, jump, jumpReg);
  modport regs (input rs, rt, destReg, regWrite, memToReg, link);

endinterface

//--- rtl/cpuCfgPkg.sv
package cpuCfgPkg;

  localparam int wordWidth = 32;
  localparam int regCount = 32;

  // Boot address of the MIPS reset exception vector
  localparam logic [wordWidth-1:0] resetVector = 32'hBFC00000;

  // Architectural register indices
  localparam int linkReg = 31;
  localparam int v0Reg = 2;

endpackage

//--- rtl/mipsIsaPkg.sv
package mipsIsaPkg;

  // Instruction field widths
  localparam int opWidth = 6;
  localparam int regAddrWidth = 5;
  localparam int shamtWidth = 5;
  localparam int immWidth = 16;
  localparam int targetWidth = 26;

  // Primary opcodes
  localparam logic [opWidth-1:0] opSpecial = 6'h00;
  localparam logic [opWidth-1:0] opJ = 6'h02;
  localparam logic [opWidth-1:0] opJal = 6'h03;
  localparam logic [opWidth-1:0] opBeq = 6'h04;
  localparam logic [opWidth-1:0] opBne = 6'h05;
  localparam logic [opWidth-1:0] opAddiu = 6'h09;
  localparam logic [opWidth-1:0] opSlti = 6'h0A;
  localparam logic [opWidth-1:0] opSltiu = 6'h0B;
  localparam logic [opWidth-1:0] opAndi = 6'h0C;
  localparam logic [opWidth-1:0] opOri = 6'h0D;
  localparam logic [opWidth-1:0] opXori = 6'h0E;
  localparam logic [opWidth-1:0] opLui = 6'h0F;
  localparam logic [opWidth-1:0] opLw = 6'h23;
  localparam logic [opWidth-1:0] opSw = 6'h2B;

  // Function codes under opSpecial
  localparam logic [opWidth-1:0] fnSll = 6'h00;
  localparam logic [opWidth-1:0] fnSrl = 6'h02;
  localparam logic [opWidth-1:0] fnSra = 6'h03;
  localparam logic [opWidth-1:0] fnJr = 6'h08;
  localparam logic [opWidth-1:0] fnAddu = 6'h21;
  localparam logic [opWidth-1:0] fnSubu = 6'h23;
  localparam logic [opWidth-1:0] fnAnd = 6'h24;
  localparam logic [opWidth-1:0] fnOr = 6'h25;
  localparam logic [opWidth-1:0] fnXor = 6'h26;
  localparam logic [opWidth-1:0] fnNor = 6'h27;
  localparam logic [opWidth-1:0] fnSlt = 6'h2A;
  localparam logic [opWidth-1:0] fnSltu = 6'h2B;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
    aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
  } aluOp_t;

endpackage
